// File: filelist.f
src/flash_fetch_pkg.sv
src/flash_rd_if.sv
src/fetch_req_stage.sv
src/spi_read_engine.sv
src/fetch_resp_stage.sv
src/flash_fetch_top.sv
tests/spi_flash_model.sv
tests/flash_fetch_properties.sv
tests/flash_fetch_tb.sv

// File: tests/flash_fetch_tb.sv
module flash_fetch_tb import flash_fetch_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam flash_addr_t BASE = 24'h10_0000;
  localparam int NUM_FETCHES = 25;
  localparam int WATCHDOG_CYCLES = NUM_FETCHES * 200 + 2000;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  fetch_addr_t req_addr;
  logic        req_ready;
  logic        resp_valid;
  instr_t      resp_data;
  logic        resp_ready;
  logic        spi_cs;
  logic        spi_sclk;
  logic        spi_mosi;
  logic        spi_miso;

  int     mismatches;
  int     failures;
  instr_t exp_q [$];

  flash_fetch_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .resp_ready (resp_ready),
    .spi_cs     (spi_cs),
    .spi_sclk   (spi_sclk),
    .spi_mosi   (spi_mosi),
    .spi_miso   (spi_miso)
  );

  spi_flash_model flash (
    .cs   (spi_cs),
    .sclk (spi_sclk),
    .mosi (spi_mosi),
    .miso (spi_miso)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic flash_addr_t expected_addr(fetch_addr_t a);
    return BASE + (flash_addr_t'(a) << 1);
  endfunction

  // big-endian word, lower address is the upper byte
  function automatic instr_t expected_word(fetch_addr_t a);
    flash_addr_t ba;
    ba = expected_addr(a);
    return {flash.mem[ba], flash.mem[ba + 1]};
  endfunction

  task automatic check_instr(string name, instr_t got, instr_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
      mismatches++;
    end
  endtask

  task automatic check_addr(string name, flash_addr_t got, flash_addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
      mismatches++;
    end
  endtask

  task automatic check_byte(string name, spi_byte_t got, spi_byte_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
      mismatches++;
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
      mismatches++;
    end
  endtask

  // results are popped in request order
  always @(posedge clk) begin
    instr_t exp;
    if (rst_n && resp_valid && resp_ready) begin
      if (exp_q.size() == 0) begin
        $display("result %h arrived with no fetch outstanding at %0t", resp_data, $time);
        failures++;
      end else begin
        exp = exp_q.pop_front();
        check_instr("resp_data", resp_data, exp);
      end
    end
  end

  task automatic reset_dut();
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    exp_q.delete();
  endtask

  task automatic send_req(fetch_addr_t a);
    req_valid = 1'b1;
    req_addr  = a;
    @(posedge clk);
    while (!req_ready) @(posedge clk);
    exp_q.push_back(expected_word(a));
    #2;
    req_valid = 1'b0;
  endtask

  task automatic wait_drain(int limit);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < limit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d results still missing after %0d cycles", exp_q.size(), limit);
      failures++;
      exp_q.delete();
    end
    @(posedge clk);
    #2;
  endtask

  task automatic fetch_one(fetch_addr_t a);
    send_req(a);
    wait_drain(300);
    check_byte("flash command", flash.last_cmd, READ_CMD);
    check_addr("flash address", flash.last_addr, expected_addr(a));
  endtask

  task automatic test_single_zero();
    fetch_one('0);
  endtask

  task automatic test_addr_sweep();
    fetch_one(15'h0001);
    fetch_one(15'h7FFF);
    for (int i = 0; i < 4; i++) begin
      fetch_one(fetch_addr_t'($urandom));
    end
  endtask

  task automatic test_back_to_back();
    fetch_addr_t start_a;
    start_a = fetch_addr_t'($urandom);
    for (int i = 0; i < 8; i++) begin
      send_req(start_a + fetch_addr_t'(i * 3));
    end
    wait_drain(8 * 200);
  endtask

  task automatic test_back_pressure();
    int   stretch;
    logic held_low;
    stretch    = 300 + int'($urandom % 200);
    held_low   = 1'b0;
    resp_ready = 1'b0;
    fork
      begin
        for (int i = 0; i < 6; i++) begin
          send_req(fetch_addr_t'($urandom));
        end
      end
      begin
        // by now all three stages are full
        repeat (stretch) @(posedge clk);
        held_low = !req_ready;
        #2;
        resp_ready = 1'b1;
      end
    join
    if (!held_low) begin
      $display("req_ready still high after %0d cycles of held results", stretch);
      failures++;
    end
    wait_drain(6 * 200);
  endtask

  task automatic test_reset_mid();
    // result slot, engine and input stage all occupied when reset hits
    resp_ready = 1'b0;
    for (int i = 0; i < 3; i++) begin
      send_req(fetch_addr_t'($urandom));
    end
    while (spi_cs) @(posedge clk);
    repeat (40) @(posedge clk);
    #2;
    reset_dut();
    resp_ready = 1'b1;
    check_bit("spi_cs", spi_cs, 1'b1);
    check_bit("spi_sclk", spi_sclk, 1'b1);
    check_bit("resp_valid", resp_valid, 1'b0);
    check_bit("req_ready", req_ready, 1'b1);
    fetch_one(fetch_addr_t'($urandom));
  endtask

  initial begin
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_addr   = '0;
    resp_ready = 1'b1;
    mismatches = 0;
    failures   = 0;
    reset_dut();
    test_single_zero();
    test_addr_sweep();
    test_back_to_back();
    test_back_pressure();
    test_reset_mid();
    repeat (5) @(posedge clk);
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures, dut.u_props.fail_count);
    if (mismatches == 0 && failures == 0 && dut.u_props.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: tests/flash_fetch_properties.sv
module flash_fetch_properties import flash_fetch_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        req_valid,
  input fetch_addr_t req_addr,
  input logic        req_ready,
  input logic        resp_valid,
  input instr_t      resp_data,
  input logic        resp_ready,
  input logic        spi_cs,
  input logic        spi_sclk
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  // sclk parked high outside a transaction
  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n) spi_cs |-> spi_sclk)
    else begin
      fail_count++;
      $error("spi_sclk low while spi_cs is high");
    end

  a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_data)))
    else begin
      fail_count++;
      $error("result dropped or changed before it was accepted");
    end

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (req_valid && !req_ready) |=> (req_valid && $stable(req_addr)))
    else begin
      fail_count++;
      $error("request dropped or changed before it was accepted");
    end

endmodule

bind flash_fetch_top flash_fetch_properties u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .req_valid  (req_valid),
  .req_addr   (req_addr),
  .req_ready  (req_ready),
  .resp_valid (resp_valid),
  .resp_data  (resp_data),
  .resp_ready (resp_ready),
  .spi_cs     (spi_cs),
  .spi_sclk   (spi_sclk)
);

// File: tests/spi_flash_model.sv
module spi_flash_model import flash_fetch_pkg::*; (
  input  logic cs,
  input  logic sclk,
  input  logic mosi,
  output logic miso
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_BITS = 21;
  localparam int MEM_BYTES = 1 << ADDR_BITS;

  spi_byte_t   mem [MEM_BYTES];
  spi_byte_t   last_cmd;
  flash_addr_t last_addr;
  int unsigned bits_in;
  int unsigned bits_out;
  logic [31:0] rx_shift;

  // random contents with the address folded in
  initial begin
    int unsigned seed_val;
    seed_val = $urandom(95);
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i] = spi_byte_t'($urandom) ^ spi_byte_t'(i ^ (i >> 8) ^ (i >> 16));
    end
    miso      = 1'b0;
    last_cmd  = '0;
    last_addr = '0;
    bits_in   = 0;
    bits_out  = 0;
    rx_shift  = '0;
  end

  // new transaction
  always @(negedge cs) begin
    bits_in  = 0;
    bits_out = 0;
  end

  // mosi sampled on the rising edge
  always @(posedge sclk) begin
    if (!cs) begin
      rx_shift = {rx_shift[30:0], mosi};
      bits_in  = bits_in + 1;
      if (bits_in == 8) begin
        last_cmd = rx_shift[7:0];
      end
      if (bits_in == 32) begin
        last_addr = rx_shift[23:0];
      end
    end
  end

  // data out msb first on the falling edge, address auto-increments
  always @(negedge sclk) begin
    flash_addr_t rd_addr;
    spi_byte_t   cur;
    if (!cs && bits_in >= 32 && last_cmd == READ_CMD) begin
      rd_addr  = last_addr + flash_addr_t'(bits_out >> 3);
      cur      = mem[rd_addr[ADDR_BITS-1:0]];
      miso     = cur[7 - (bits_out % 8)];
      bits_out = bits_out + 1;
    end
  end

endmodule

// File: src/flash_fetch_top.sv
module flash_fetch_top import flash_fetch_pkg::*; #(
  parameter flash_addr_t FLASH_BASE = 24'h10_0000
) (
  input  logic        clk,
  input  logic        rst_n,

  // fetch requests
  input  logic        req_valid,
  input  fetch_addr_t req_addr,
  output logic        req_ready,

  // instruction words out
  output logic        resp_valid,
  output instr_t      resp_data,
  input  logic        resp_ready,

  // serial flash
  output logic        spi_cs,
  output logic        spi_sclk,
  output logic        spi_mosi,
  input  logic        spi_miso
);

  flash_rd_if rd_bus ();

  fetch_req_stage #(
    .FLASH_BASE (FLASH_BASE)
  ) u_req (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .req_ready  (req_ready),
    .rd         (rd_bus.req)
  );

  spi_read_engine u_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd         (rd_bus.engine),
    .spi_cs     (spi_cs),
    .spi_sclk   (spi_sclk),
    .spi_mosi   (spi_mosi),
    .spi_miso   (spi_miso)
  );

  fetch_resp_stage u_resp (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd         (rd_bus.resp),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .resp_ready (resp_ready)
  );

endmodule

// File: src/fetch_resp_stage.sv
module fetch_resp_stage import flash_fetch_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  flash_rd_if.resp rd,
  output logic     resp_valid,
  output instr_t   resp_data,
  input  logic     resp_ready
);

  logic   full;
  instr_t data_q;
  logic   accept;

  // consumer takes the word this cycle
  assign accept = full && resp_ready;

  // a slot being drained can be refilled on the same edge
  assign rd.slot_free = !full || resp_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (rd.done) begin
      full <= 1'b1;
    end else if (accept) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd.done) begin
      data_q <= rd.data;
    end
  end

  assign resp_valid = full;
  assign resp_data  = data_q;

endmodule

// File: src/spi_read_engine.sv
module spi_read_engine import flash_fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  flash_rd_if.engine rd,
  output logic       spi_cs,
  output logic       spi_sclk,
  output logic       spi_mosi,
  input  logic       spi_miso
);

  localparam int CNT_W = 4;
  localparam logic [CNT_W-1:0] BYTE_BITS = 4'd8;

  rd_state_t        state;
  rd_state_t        state_d;
  logic [CNT_W-1:0] bit_cnt;
  spi_byte_t        shreg;
  spi_byte_t        tx_byte;
  flash_addr_t      addr_q;
  instr_t           data_q;
  logic             shifting;
  logic             byte_load;
  logic             accept;
  logic             done_pulse;

  // bits left in the current byte
  assign shifting = (bit_cnt != '0);

  assign accept     = (state == IDLE) && rd.start;
  assign done_pulse = (state == DONE) && rd.slot_free;

  // each byte state waits for its 8 bits, then one cycle to step on
  always_comb begin
    state_d = state;
    case (state)
      IDLE: begin
        if (rd.start) begin
          state_d = CMD;
        end
      end
      CMD: begin
        if (!shifting) begin
          state_d = ADDR_HI;
        end
      end
      ADDR_HI: begin
        if (!shifting) begin
          state_d = ADDR_MID;
        end
      end
      ADDR_MID: begin
        if (!shifting) begin
          state_d = ADDR_LO;
        end
      end
      ADDR_LO: begin
        if (!shifting) begin
          state_d = DATA_HI;
        end
      end
      DATA_HI: begin
        if (!shifting) begin
          state_d = DATA_LO;
        end
      end
      DATA_LO: begin
        if (!shifting) begin
          state_d = DONE;
        end
      end
      DONE: begin
        // hold the word until the result stage can take it
        if (rd.slot_free) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // a fresh byte starts on every step into a shifting state
  assign byte_load = (state_d != state) && (state_d != IDLE) && (state_d != DONE);

  // outgoing byte for the state being entered, msb first
  always_comb begin
    case (state_d)
      CMD:      tx_byte = READ_CMD;
      ADDR_HI:  tx_byte = addr_q[23:16];
      ADDR_MID: tx_byte = addr_q[15:8];
      ADDR_LO:  tx_byte = addr_q[7:0];
      default:  tx_byte = '0;
    endcase
  end

  // mode 3 bus: sclk idles high, mosi moves on the fall, miso sampled on the rise
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      bit_cnt  <= '0;
      spi_cs   <= 1'b1;
      spi_sclk <= 1'b1;
      spi_mosi <= 1'b0;
    end else begin
      state <= state_d;
      if (byte_load) begin
        bit_cnt <= BYTE_BITS;
      end else if (shifting) begin
        if (spi_sclk) begin
          spi_sclk <= 1'b0;
          spi_mosi <= shreg[7];
        end else begin
          spi_sclk <= 1'b1;
          bit_cnt  <= bit_cnt - 1'b1;
        end
      end
      if (accept) begin
        spi_cs <= 1'b0;
      end else if (done_pulse) begin
        spi_cs <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= rd.byte_addr;
    end
    if (byte_load) begin
      shreg <= tx_byte;
    end else if (shifting && !spi_sclk) begin
      shreg <= {shreg[6:0], spi_miso};
    end
    // first byte in is the upper half
    if (!shifting && (state == DATA_HI)) begin
      data_q[15:8] <= shreg;
    end
    if (!shifting && (state == DATA_LO)) begin
      data_q[7:0] <= shreg;
    end
  end

  assign rd.busy = (state != IDLE);
  assign rd.done = done_pulse;
  assign rd.data = data_q;

endmodule

// File: src/fetch_req_stage.sv
module fetch_req_stage import flash_fetch_pkg::*; #(
  parameter flash_addr_t FLASH_BASE = 24'h10_0000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_valid,
  input  fetch_addr_t req_addr,
  output logic        req_ready,
  flash_rd_if.req     rd
);

  logic        pend_valid;
  flash_addr_t pend_addr;
  flash_addr_t byte_offset;
  logic        accept;
  logic        issue;

  // two bytes per instruction word
  assign byte_offset = flash_addr_t'({req_addr, 1'b0});

  // single holding slot, so no new request while one is waiting
  assign req_ready = !pend_valid;
  assign accept    = req_valid && req_ready;

  // hand the request over as soon as the engine is idle
  assign issue = pend_valid && !rd.busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_valid <= 1'b0;
    end else if (accept) begin
      pend_valid <= 1'b1;
    end else if (issue) begin
      pend_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pend_addr <= FLASH_BASE + byte_offset;
    end
  end

  assign rd.start     = issue;
  assign rd.byte_addr = pend_addr;

endmodule

// File: src/flash_rd_if.sv
interface flash_rd_if import flash_fetch_pkg::*; ();

  // request side
  logic        start;
  flash_addr_t byte_addr;
  logic        busy;

  // result side
  logic        done;
  instr_t      data;
  logic        slot_free;

  modport req (
    output start,
    output byte_addr,
    input  busy
  );

  modport engine (
    input  start,
    input  byte_addr,
    input  slot_free,
    output busy,
    output done,
    output data
  );

  modport resp (
    input  done,
    input  data,
    output slot_free
  );

endinterface

// File: src/flash_fetch_pkg.sv
package flash_fetch_pkg;

  // instruction word address from the requester
  typedef logic [14:0] fetch_addr_t;

  // byte address on the serial flash
  typedef logic [23:0] flash_addr_t;

  // one instruction word, big-endian on the flash
  typedef logic [15:0] instr_t;

  // one byte on the spi bus
  typedef logic [7:0] spi_byte_t;

  // standard slow READ opcode
  localparam spi_byte_t READ_CMD = 8'h03;

  // engine states, one per byte on the wire plus idle and done
  typedef enum logic [2:0] {
    IDLE,
    CMD,
    ADDR_HI,
    ADDR_MID,
    ADDR_LO,
    DATA_HI,
    DATA_LO,
    DONE
  } rd_state_t;

endpackage
